// File: include/sad_settings.svh
`ifndef SAD_SETTINGS_SVH
`define SAD_SETTINGS_SVH

// reference length, also the number of lanes
`define SAD_REF_SAMPLES 32

// one adc sample
`define SAD_SAMPLE_BITS 8

// accumulator width, msb flags saturation
`define SAD_SUM_BITS 16

// enough to address every reference entry
`define SAD_INDEX_BITS 5

// edges from the last window sample to trigger
`define SAD_MATCH_LATENCY 4

`endif

// File: src/sad_pkg.sv
`include "sad_settings.svh"

package sad_pkg;

    // raw adc or reference sample
    typedef logic [`SAD_SAMPLE_BITS-1:0] sample_t;

    // running sad, also used for the threshold
    typedef logic [`SAD_SUM_BITS-1:0] sum_t;

    // reference address or window phase
    typedef logic [`SAD_INDEX_BITS-1:0] index_t;

    // one bit per lane
    typedef logic [`SAD_REF_SAMPLES-1:0] lane_mask_t;

    typedef enum logic [1:0] {
        IDLE,
        FILLING,    // first window not complete yet
        MATCHING
    } run_state_t;

endpackage

// File: src/sad_lane_if.sv
`timescale 1ns/1ns

interface sad_lane_if;
    import sad_pkg::*;

    sample_t    ref_head;   // reference entry at the current phase
    lane_mask_t restart;    // lanes closing one window and opening the next
    lane_mask_t ready;      // lanes whose windows lie inside the run
    logic       running;
    lane_mask_t match;      // per lane compare result, one cycle wide

    modport store (
        output ref_head,
        input  running
    );

    modport timer (
        output restart,
        output ready,
        input  running
    );

    modport fsm (
        output running,
        input  ready,
        input  match
    );

    modport lanes (
        input  ref_head,
        input  restart,
        output match
    );

endinterface

// File: src/sad_run_fsm.sv
`timescale 1ns/1ns

module sad_run_fsm (
    input  logic        adc_sampleclk,
    input  logic        reset,
    input  logic        armed_and_ready,
    input  logic        active,
    input  logic        multiple_triggers,
    input  logic        clear_status,
    sad_lane_if.fsm     lane,
    output logic        trigger,
    output logic        triggered,
    output logic [15:0] num_triggers
);
    import sad_pkg::*;

    run_state_t state;
    logic       run_start;
    logic       hit_any;
    logic       locked;
    logic       fire;

    assign lane.running = armed_and_ready & active;
    assign run_start    = lane.running && (state == IDLE);

    // only lanes with a full window inside the run may count
    assign hit_any = |(lane.match & lane.ready);

    // single trigger mode: hold off once fired, including the edge right after
    assign locked = !multiple_triggers && (triggered || trigger);
    assign fire   = lane.running && hit_any && !locked;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !lane.running) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= FILLING;
                FILLING: begin
                    if (|lane.ready)
                        state <= MATCHING;
                end
                default: state <= MATCHING;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            trigger <= 1'b0;
        else
            trigger <= fire;
    end

    // status is zeroed by a clear pulse or a fresh run
    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_status || run_start) begin
            triggered    <= 1'b0;
            num_triggers <= '0;
        end else if (trigger) begin
            triggered    <= 1'b1;
            num_triggers <= num_triggers + 16'd1;
        end
    end

    // ready is dropped outside a run, so no stale lane can fire after idle
    a_no_trigger_after_idle: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        (state == IDLE) |=> !trigger
    );

endmodule

// File: src/sad_window_timer.sv
`timescale 1ns/1ns
`include "sad_settings.svh"

module sad_window_timer (
    input  logic            adc_sampleclk,
    input  logic            reset,
    input  logic            sad_short,
    sad_lane_if.timer       lane,
    output sad_pkg::index_t phase
);
    import sad_pkg::*;

    localparam int LANES = `SAD_REF_SAMPLES;

    // lane i restarts two edges after the run takes sample i (mod W),
    // the pipeline depth ahead of the accumulators
    localparam lane_mask_t LONG_SEED  = lane_mask_t'(1) << (LANES - 2);
    localparam lane_mask_t SHORT_SEED = LONG_SEED | (lane_mask_t'(1) << (LANES / 2 - 2));

    index_t     phase_top;
    lane_mask_t seed;
    logic       wrap;

    assign phase_top = sad_short ? index_t'(LANES / 2 - 1) : index_t'(LANES - 1);
    assign seed      = sad_short ? SHORT_SEED : LONG_SEED;
    assign wrap      = (phase == phase_top);

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !lane.running) begin
            phase        <= '0;
            lane.restart <= seed;
            lane.ready   <= '0;
        end else begin
            phase        <= wrap ? '0 : index_t'(phase + 1'b1);
            lane.restart <= {lane.restart[LANES-2:0], lane.restart[LANES-1]};
            // bit 0 latches after the first full window, then walks up
            lane.ready   <= {lane.ready[LANES-2:0], lane.ready[0] | wrap};
        end
    end

    // the seed loaded while idle must match the mode used in the run
    a_restart_hot: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        lane.running |-> ($countones(lane.restart) == (sad_short ? 2 : 1))
    );

endmodule

// File: src/sad_reference_store.sv
`timescale 1ns/1ns
`include "sad_settings.svh"

module sad_reference_store (
    input  logic            adc_sampleclk,
    input  logic            reset,
    input  logic            ref_write,
    input  sad_pkg::index_t ref_index,
    input  sad_pkg::sample_t ref_data,
    input  sad_pkg::index_t phase,
    sad_lane_if.store       lane
);
    import sad_pkg::*;

    localparam int DEPTH = `SAD_REF_SAMPLES;

    sample_t ref_mem [DEPTH];

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                ref_mem[i] <= '0;
            end
        end else if (ref_write) begin
            ref_mem[ref_index] <= ref_data; // one entry per strobe
        end
    end

    // head of the reference delay chain, one edge behind phase
    always_ff @(posedge adc_sampleclk) begin
        lane.ref_head <= ref_mem[phase];
    end

    // the lanes read the table every cycle of a run
    a_no_write_in_run: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        lane.running |-> !ref_write
    );

endmodule

// File: src/sad_lane_array.sv
`timescale 1ns/1ns
`include "sad_settings.svh"

module sad_lane_array (
    input  logic             adc_sampleclk,
    input  sad_pkg::sample_t adc_datain,
    input  sad_pkg::sum_t    threshold,
    sad_lane_if.lanes        lane
);
    import sad_pkg::*;

    localparam int LANES   = `SAD_REF_SAMPLES;
    localparam int SUM_TOP = `SAD_SUM_BITS - 1;

    sample_t         sample_r;
    sample_t         sample_rr;        // lines up with ref_dly
    sample_t         ref_dly [LANES];  // ref_dly[i] is ref_head delayed i+1 edges
    wire lane_mask_t hits;

    always_ff @(posedge adc_sampleclk) begin
        sample_r   <= adc_datain;
        sample_rr  <= sample_r;
        ref_dly[0] <= lane.ref_head;
        for (int i = 1; i < LANES; i++) begin
            ref_dly[i] <= ref_dly[i-1];
        end
    end

    // each lane sees the same samples against a reference shifted by its index,
    // so a window that starts on lane i's restart uses entries 0..W-1 in order
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        sum_t abs_diff;
        sum_t sad_sum;
        logic hit;

        always_comb begin
            if (sample_rr > ref_dly[i])
                abs_diff = sum_t'(sample_rr) - sum_t'(ref_dly[i]);
            else
                abs_diff = sum_t'(ref_dly[i]) - sum_t'(sample_rr);
        end

        always_ff @(posedge adc_sampleclk) begin
            if (lane.restart[i]) begin
                // close the old window, open the new one with this difference
                hit     <= !sad_sum[SUM_TOP] && (sad_sum <= threshold);
                sad_sum <= abs_diff;
            end else begin
                hit <= 1'b0;
                if (!sad_sum[SUM_TOP])
                    sad_sum <= sad_sum + abs_diff;  // sticks once msb is set
            end
        end

        assign hits[i] = hit;
    end

    assign lane.match = hits;

endmodule

// File: src/sad_trigger.sv
`timescale 1ns/1ns

module sad_trigger (
    input  logic             adc_sampleclk,
    input  logic             reset,
    input  sad_pkg::sample_t adc_datain,
    input  logic             armed_and_ready,
    input  logic             active,
    input  logic             ref_write,
    input  sad_pkg::index_t  ref_index,
    input  sad_pkg::sample_t ref_data,
    input  sad_pkg::sum_t    threshold,
    input  logic             sad_short,
    input  logic             multiple_triggers,
    input  logic             clear_status,
    output logic             trigger,
    output logic             triggered,
    output logic [15:0]      num_triggers
);
    import sad_pkg::*;

    index_t phase;  // reference read address for the lane chain

    sad_lane_if u_lane_if ();

    sad_run_fsm u_run_fsm (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .armed_and_ready   (armed_and_ready),
        .active            (active),
        .multiple_triggers (multiple_triggers),
        .clear_status      (clear_status),
        .lane              (u_lane_if.fsm),
        .trigger           (trigger),
        .triggered         (triggered),
        .num_triggers      (num_triggers)
    );

    sad_window_timer u_window_timer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .sad_short     (sad_short),
        .lane          (u_lane_if.timer),
        .phase         (phase)
    );

    sad_reference_store u_reference_store (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .ref_write     (ref_write),
        .ref_index     (ref_index),
        .ref_data      (ref_data),
        .phase         (phase),
        .lane          (u_lane_if.store)
    );

    sad_lane_array u_lane_array (
        .adc_sampleclk (adc_sampleclk),
        .adc_datain    (adc_datain),
        .threshold     (threshold),
        .lane          (u_lane_if.lanes)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;    // half period per phase
        end
    end

endmodule

// File: tb/sad_trigger_tb.sv
`timescale 1ns/1ns
`include "sad_settings.svh"

module sad_trigger_tb;
    import sad_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int LANES      = `SAD_REF_SAMPLES;
    localparam int LATENCY    = `SAD_MATCH_LATENCY;
    localparam int REC_WORDS  = 8;      // 32-bit words per test record
    localparam int MAX_TESTS  = 16;
    localparam int MAX_RUN    = 1024;
    localparam int SAT_LIMIT  = 1 << (`SAD_SUM_BITS - 1);

    logic        clk;
    logic        reset;
    sample_t     adc_datain;
    logic        armed_and_ready;
    logic        active;
    logic        ref_write;
    index_t      ref_index;
    sample_t     ref_data;
    sum_t        threshold;
    logic        sad_short;
    logic        multiple_triggers;
    logic        clear_status;
    logic        trigger;
    logic        triggered;
    logic [15:0] num_triggers;

    logic [31:0] vec_mem [0:REC_WORDS*MAX_TESTS-1];
    string       test_name;
    integer      seed;
    int          errors;
    int          checks;
    int          test_errors;
    int          tests_run;
    int          watchdog_cycles;

    // reference model state
    sample_t model_ref [LANES];
    sample_t run_hist [MAX_RUN];    // samples of the current run, index 0 first
    int      run_len;
    logic    run_prev;
    logic    fired;                 // trigger seen since last clear or run start
    logic    exp_trigger;
    logic    exp_triggered;
    int      exp_count;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_tb_clock (.clk(clk));

    sad_trigger u_sad_trigger (
        .adc_sampleclk     (clk),
        .reset             (reset),
        .adc_datain        (adc_datain),
        .armed_and_ready   (armed_and_ready),
        .active            (active),
        .ref_write         (ref_write),
        .ref_index         (ref_index),
        .ref_data          (ref_data),
        .threshold         (threshold),
        .sad_short         (sad_short),
        .multiple_triggers (multiple_triggers),
        .clear_status      (clear_status),
        .trigger           (trigger),
        .triggered         (triggered),
        .num_triggers      (num_triggers)
    );

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED %s %s at %0t: expected %0d, actual %0d",
                     test_name, what, $time, expected, actual);
        end
    endtask

    function automatic sample_t next_filler();
        return sample_t'($random(seed));
    endfunction

    // sum of |sample - ref| over the window whose last sample is 'last'
    function automatic int window_sad(input int last, input int w);
        int sum;
        int d;
        sum = 0;
        for (int j = 0; j < w; j++) begin
            d = int'(run_hist[last - w + 1 + j]) - int'(model_ref[j]);
            sum += (d < 0) ? -d : d;
        end
        return sum;
    endfunction

    function automatic logic record_valid(input int base);
        return base < REC_WORDS * MAX_TESTS && !$isunknown(vec_mem[base])
               && vec_mem[base] != 0;
    endfunction

    // one edge: drive inputs, advance the model, compare after the edge
    task automatic step(input logic run, input sample_t sample, input logic clr);
        int   w;
        int   last;
        int   sad;
        logic run_start;
        logic hit;

        w               = sad_short ? LANES / 2 : LANES;
        adc_datain      = sample;
        armed_and_ready = run;
        active          = run;
        clear_status    = clr;

        run_start = run && !run_prev;
        if (run_start)
            run_len = 0;
        if (run) begin
            run_hist[run_len] = sample;
            run_len++;
        end

        // status follows the trigger of the previous edge
        if (clr || run_start) begin
            exp_triggered = 1'b0;
            exp_count     = 0;
        end else if (exp_trigger) begin
            exp_triggered = 1'b1;
            exp_count++;
        end

        last = run_len - 1 - LATENCY;   // window closed LATENCY edges back
        hit  = 1'b0;
        if (run && last >= w - 1) begin
            sad = window_sad(last, w);
            hit = (sad < SAT_LIMIT) && (sad <= threshold);
        end
        exp_trigger = hit && (multiple_triggers || !fired);
        fired       = (fired && !(clr || run_start)) || exp_trigger;
        run_prev    = run;

        @(posedge clk);
        #2;
        check_value("trigger", exp_trigger, trigger);
        check_value("triggered", exp_triggered, triggered);
        check_value("num_triggers", exp_count, num_triggers);
    endtask

    task automatic load_reference();
        for (int j = 0; j < LANES; j++) begin
            ref_write = 1'b1;
            ref_index = index_t'(j);
            ref_data  = model_ref[j];
            step(1'b0, next_filler(), 1'b0);
        end
        ref_write = 1'b0;
    endtask

    task automatic report_test();
        if (test_errors == 0)
            $display("test %s passed", test_name);
        else
            $display("test %s failed with %0d mismatches", test_name, test_errors);
    endtask

    task automatic run_test(input int base);
        logic [31:0] flags;
        logic [31:0] ref_shape;
        logic [31:0] shape;
        logic [31:0] expected;
        int          offset;
        int          reps;
        int          gap;
        int          w;

        test_name   = $sformatf("%s", {vec_mem[base], vec_mem[base+1]});
        flags       = vec_mem[base+2];
        ref_shape   = vec_mem[base+4];
        offset      = vec_mem[base+5];
        shape       = vec_mem[base+6];
        expected    = vec_mem[base+7];
        reps        = shape[23:16];
        gap         = shape[15:8];
        test_errors = 0;

        // mode is set while idle so the timer seeds the matching mask
        threshold         = sum_t'(vec_mem[base+3]);
        sad_short         = flags[0];
        multiple_triggers = flags[1];
        w                 = flags[0] ? LANES / 2 : LANES;

        for (int j = 0; j < LANES; j++) begin
            if (flags[4])
                model_ref[j] = next_filler();
            else
                model_ref[j] = sample_t'(ref_shape[15:8] + j * ref_shape[7:0]);
        end
        load_reference();
        repeat (4) step(1'b0, next_filler(), 1'b0);

        repeat (shape[31:24]) step(1'b1, next_filler(), 1'b0);     // lead filler
        for (int r = 0; r < reps; r++) begin
            for (int j = 0; j < w; j++)
                step(1'b1, sample_t'(model_ref[j] + offset), 1'b0);
            for (int g = 0; r < reps - 1 && g < gap; g++) begin
                if (flags[3] && g == gap / 2)
                    repeat (3) step(1'b0, next_filler(), 1'b0);     // run breaks here
                step(1'b1, next_filler(), flags[2] && g == gap / 2);
            end
        end
        repeat (shape[7:0]) step(1'b1, next_filler(), 1'b0);       // tail filler
        repeat (4) step(1'b0, next_filler(), 1'b0);

        if (expected != 32'h0000ffff)
            check_value("final num_triggers", expected, num_triggers);
        tests_run++;
        report_test();
    endtask

    initial begin
        int base;

        seed              = 81032;
        reset             = 1'b1;
        adc_datain        = '0;
        armed_and_ready   = 1'b0;
        active            = 1'b0;
        ref_write         = 1'b0;
        ref_index         = '0;
        ref_data          = '0;
        threshold         = '0;
        sad_short         = 1'b0;
        multiple_triggers = 1'b0;
        clear_status      = 1'b0;
        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        run_len           = 0;
        run_prev          = 1'b0;
        fired             = 1'b0;
        exp_trigger       = 1'b0;
        exp_triggered     = 1'b0;
        exp_count         = 0;

        $readmemh("tb/sad_trigger_vectors.txt", vec_mem);

        // reset, the idle check, and some slack
        watchdog_cycles = 2 * 8 + 100;
        for (base = 0; record_valid(base); base += REC_WORDS)
            watchdog_cycles += 48 + vec_mem[base+6][31:24] + vec_mem[base+6][7:0]
                + vec_mem[base+6][23:16] * (LANES + vec_mem[base+6][15:8] + 3);

        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        test_name   = "reset";
        test_errors = 0;
        repeat (8) step(1'b0, next_filler(), 1'b0);    // outputs stay quiet with no run
        tests_run++;
        report_test();

        for (base = 0; record_valid(base); base += REC_WORDS)
            run_test(base);
        if (tests_run < 2) begin
            errors++;
            $display("no test records were read from tb/sad_trigger_vectors.txt");
        end

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        #(watchdog_cycles * CLK_PERIOD);
        $display("timeout, the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Something failed");
        $finish;
    end

endmodule

// File: sad_trigger.f
+incdir+include
src/sad_pkg.sv
src/sad_lane_if.sv
src/sad_run_fsm.sv
src/sad_window_timer.sv
src/sad_reference_store.sv
src/sad_lane_array.sv
src/sad_trigger.sv
tb/tb_clock.sv
tb/sad_trigger_tb.sv

// File: tb/sad_trigger_vectors.txt
// one test per line, 32-bit hex words:
// name(2 words, ascii) flags threshold ref_base_step offset lead_reps_gap_tail expected_num
// flags: bit0 short window, bit1 multiple triggers, bit2 clear in gap,
// bit3 new run in gap, bit4 random reference
// ref_base_step: ref[j] = base + j * step; expected 0000ffff means model only
65786163 745f6c67 00000000 00000000 00001007 00000000 0a01000c 00000001
7468725f 61745f5f 00000000 00000020 00001007 00000001 0601000a 00000001
7468725f 626c775f 00000000 0000001f 00001007 00000001 0601000a 00000000
72616e64 6f6d5f5f 00000012 00000a28 00000000 00000000 78000000 0000ffff
73686f72 745f7074 00000003 00000000 00001007 00000000 0502080a 00000002
73696e67 6c655f5f 00000000 00000000 00001007 00000000 04020c0a 00000001
6d756c74 695f5f5f 00000002 00000000 00001007 00000000 04020c0a 00000002
636c6561 725f5f5f 00000004 00000000 00001007 00000000 04020c0a 00000001
6e65775f 72756e5f 00000008 00000000 00001007 00000000 04020c0a 00000001
// end marker
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
